// File: hdl/bridge_defines.svh
// AHB to OCP write-buffer bridge, shared constants
// bus widths, line fifo depth, OCP burst shape and base address
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// ---------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------
`define OCP_ADDR_W   28          // OCP maddr width
`define LINE_W       128         // one OCP beat, four AHB words
`define OFFSET_W     21          // low haddr bits kept as fill offset

// ---------------------------------------------------------------------
// line fifo and burst shape
// ---------------------------------------------------------------------
`define FIFO_DEPTH   8           // lines per fill
`define FIFO_AW      3           // line index width
`define BURST_LEN    2           // beats per precise write burst
`define BURST_BYTES  32          // maddr step per burst, 2 x 16 bytes

// OCP window seen by the AHB side
`define BASE_ADDR    28'h0800000

`endif

// File: hdl/ahb_pkg.sv
// AHB slave side types of the write-buffer bridge
// transfer type, response code and one sampled address phase
`default_nettype none

package ahb_pkg;

  // htrans encoding
  typedef enum logic [1:0] {
    HT_IDLE   = 2'b00,
    HT_BUSY   = 2'b01,
    HT_NONSEQ = 2'b10,
    HT_SEQ    = 2'b11
  } htrans_e;

  // hresp, retry and split never returned
  typedef enum logic [1:0] {
    HR_OKAY  = 2'b00,
    HR_ERROR = 2'b01
  } hresp_e;

  // one address phase as seen on the bus, 37 bits
  typedef struct packed {
    logic        sel;       // hsel
    htrans_e     trans;
    logic [31:0] addr;
    logic        write;
    logic        ready_in;  // bus hready
  } ahb_addr_s;

endpackage

`default_nettype wire

// File: hdl/ocp_pkg.sv
// OCP master side types of the write-buffer bridge
// command and response codes, 128-bit line view, request and
// response bundles
`include "bridge_defines.svh"
`default_nettype none

package ocp_pkg;

  typedef enum logic [2:0] {
    CMD_IDLE = 3'd0,
    CMD_WR   = 3'd1,
    CMD_RD   = 3'd2
  } mcmd_e;

  typedef enum logic [1:0] {
    RESP_NULL = 2'd0,
    RESP_DVA  = 2'd1,
    RESP_FAIL = 2'd2,
    RESP_ERR  = 2'd3
  } sresp_e;

  // one line, flat for the OCP data bus or split into AHB words
  typedef union packed {
    logic [`LINE_W-1:0] flat;
    logic [3:0][31:0]   word;   // word[n] sits at haddr[3:2] == n
  } ocp_line_u;

  // request group, 31 bits
  typedef struct packed {
    mcmd_e                  mcmd;
    logic [`OCP_ADDR_W-1:0] maddr;
  } ocp_cmd_s;

  // write data group, 130 bits
  typedef struct packed {
    logic [`LINE_W-1:0] mdata;
    logic               mdatavalid;
    logic               mdatalast;
  } ocp_data_s;

  // response group, 131 bits
  typedef struct packed {
    sresp_e             sresp;
    logic               sresplast;
    logic [`LINE_W-1:0] sdata;
  } ocp_resp_s;

endpackage

`default_nettype wire

// File: hdl/ahb_wr_pack.sv
// AHB input side of the write-buffer bridge
// qualifies transfers, packs write words into 128-bit lines and
// latches the fill offset and the single read address
`include "bridge_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module ahb_wr_pack import ahb_pkg::*, ocp_pkg::*; (
  input  wire logic              hclk,
  input  wire logic              n_hreset,
  input  wire ahb_addr_s         ahb_i,
  input  wire logic [31:0]       hwdata_i,
  input  wire logic              hready_i,     // bridge's own hready
  output ocp_line_u              line_o,
  output logic                   line_wr_o,    // line complete, one cycle
  output logic [`OFFSET_W-1:0]   offset_o,
  output logic                   rd_req_o,
  output logic [1:0]             rd_slot_o,
  output logic [`OCP_ADDR_W-1:0] rd_addr_o
);

  localparam logic [`FIFO_AW+1:0] LAST_WORD = (`FIFO_AW+2)'(`FIFO_DEPTH * 4 - 1);

  logic                ahb_valid;
  logic                wr_valid;
  logic                wr_dphase;   // write data phase this cycle
  logic [1:0]          wr_slot;     // haddr[3:2] of that data phase
  logic [`FIFO_AW+1:0] word_cnt;    // words taken in current fill
  ocp_line_u           line_q;

  assign ahb_valid = ahb_i.sel & ahb_i.ready_in & hready_i &
                     ((ahb_i.trans == HT_NONSEQ) | (ahb_i.trans == HT_SEQ));
  assign wr_valid  = ahb_valid & ahb_i.write;
  assign rd_req_o  = ahb_valid & ~ahb_i.write;   // fsm decides if taken

  // ---------------------------------------------------------------------
  // address phase tracking
  // ---------------------------------------------------------------------
  always_ff @(posedge hclk or negedge n_hreset) begin
    if (!n_hreset) begin
      wr_dphase <= 1'b0;
      wr_slot   <= 2'd0;
      word_cnt  <= '0;
      line_wr_o <= 1'b0;
      offset_o  <= '0;
    end else begin
      wr_dphase <= wr_valid;
      line_wr_o <= wr_dphase & (wr_slot == 2'd3);  // slot 3 closes line
      if (wr_valid) begin
        wr_slot <= ahb_i.addr[3:2];
        if (word_cnt == '0)
          offset_o <= ahb_i.addr[`OFFSET_W-1:0];   // first word of fill
        if (word_cnt == LAST_WORD)
          word_cnt <= '0;
        else
          word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // word packing and read latch
  always_ff @(posedge hclk) begin
    if (wr_dphase)
      line_q.word[wr_slot] <= hwdata_i;
    if (rd_req_o) begin
      rd_slot_o <= ahb_i.addr[3:2];
      rd_addr_o <= {ahb_i.addr[`OCP_ADDR_W-1:4], 4'h0};  // 16 byte aligned
    end
  end

  assign line_o = line_q;   // stays whole while next line's word 0 lands

endmodule

`default_nettype wire

// File: hdl/line_fifo.sv
// line FIFO of the write-buffer bridge
// fills `FIFO_DEPTH lines, then streams them as OCP write beats
// under sdataaccept, mdatalast on every second beat
`include "bridge_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module line_fifo import ocp_pkg::*; (
  input  wire logic      hclk,
  input  wire logic      n_hreset,
  input  wire ocp_line_u line_i,
  input  wire logic      line_wr_i,
  input  wire logic      sdataaccept_i,
  output ocp_data_s      data_o,
  output logic           drain_o,
  output logic           empty_o,
  output logic           last_line_wr_o
);

  localparam logic [`FIFO_AW-1:0] LAST_IDX = `FIFO_AW'(`FIFO_DEPTH - 1);

  logic [`LINE_W-1:0]  mem [`FIFO_DEPTH];
  logic [`FIFO_AW-1:0] wr_cnt;
  logic [`FIFO_AW-1:0] rd_cnt;
  logic                drain_q;
  logic                beat_valid;
  logic                beat_done;   // current beat taken by slave

  assign last_line_wr_o = line_wr_i & (wr_cnt == LAST_IDX);
  assign beat_done      = beat_valid & sdataaccept_i;

  always_ff @(posedge hclk) begin
    if (line_wr_i)
      mem[wr_cnt] <= line_i.flat;
  end

  // ---------------------------------------------------------------------
  // fill and drain counters
  // ---------------------------------------------------------------------
  always_ff @(posedge hclk or negedge n_hreset) begin
    if (!n_hreset) begin
      wr_cnt     <= '0;
      rd_cnt     <= '0;
      drain_q    <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      if (line_wr_i)
        wr_cnt <= last_line_wr_o ? '0 : wr_cnt + 1'b1;

      if (last_line_wr_o)
        drain_q <= 1'b1;                      // fifo full, start drain
      else if (beat_done & (rd_cnt == LAST_IDX))
        drain_q <= 1'b0;

      if (beat_done) begin
        if (rd_cnt == LAST_IDX) begin
          beat_valid <= 1'b0;
          rd_cnt     <= '0;
        end else begin
          rd_cnt <= rd_cnt + 1'b1;            // next beat right away
        end
      end else if (drain_q & ~beat_valid) begin
        beat_valid <= 1'b1;                   // beat 0, cycle after drain
      end
    end
  end

  // beat held until sdataaccept
  assign data_o.mdata      = mem[rd_cnt];
  assign data_o.mdatavalid = beat_valid;
  assign data_o.mdatalast  = beat_valid & ((rd_cnt % `BURST_LEN) == (`BURST_LEN - 1));

  assign drain_o = drain_q;
  assign empty_o = (wr_cnt == '0) & ~drain_q;

endmodule

`default_nettype wire

// File: hdl/ocp_cmd_fsm.sv
// OCP command sequencer of the write-buffer bridge
// one WR command per two-beat burst while draining, then waits for
// every sresplast; a single RD command per AHB read
`include "bridge_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module ocp_cmd_fsm import ocp_pkg::*; (
  input  wire logic                   hclk,
  input  wire logic                   n_hreset,
  input  wire logic                   drain_i,
  input  wire logic                   empty_i,
  input  wire logic [`OFFSET_W-1:0]   offset_i,
  input  wire logic                   rd_req_i,
  input  wire logic [`OCP_ADDR_W-1:0] rd_addr_i,
  input  wire logic                   scmdaccept_i,
  input  wire ocp_resp_s              resp_i,
  output ocp_cmd_s                    cmd_o,
  output logic                        wr_busy_o,
  output logic                        rd_busy_o,
  output ocp_line_u                   rd_line_o,
  output logic                        rd_err_o,
  output logic                        hdata_o
);

  localparam int NUM_CMD = `FIFO_DEPTH / `BURST_LEN;
  localparam logic [`FIFO_AW-1:0] LAST_CMD = `FIFO_AW'(NUM_CMD - 1);
  localparam logic [`FIFO_AW-1:0] ALL_RESP = `FIFO_AW'(NUM_CMD);

  typedef enum logic [2:0] {
    S_IDLE, S_MCMD_WR, S_WAIT, S_MCMD_RD, S_SDATA, S_HDATA
  } state_e;

  state_e                 state;
  state_e                 nxt_state;
  logic [`FIFO_AW-1:0]    cmd_cnt;    // write commands accepted
  logic [`FIFO_AW-1:0]    resp_cnt;   // sresplast seen this drain
  logic [`OCP_ADDR_W-1:0] wr_addr;
  logic                   rd_start;
  logic                   resp_seen;

  assign rd_start  = rd_req_i & empty_i;   // no read while lines wait
  assign resp_seen = (resp_i.sresp != RESP_NULL);

  // base + offset + k bursts
  assign wr_addr = `BASE_ADDR + `OCP_ADDR_W'(offset_i) +
                   `OCP_ADDR_W'(cmd_cnt * `BURST_BYTES);

  // ---------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------
  always_comb begin
    nxt_state = state;
    case (state)
      S_IDLE: begin
        if (drain_i)
          nxt_state = S_MCMD_WR;
        else if (rd_start)
          nxt_state = S_MCMD_RD;
      end
      S_MCMD_WR: begin
        if (scmdaccept_i & (cmd_cnt == LAST_CMD))
          nxt_state = S_WAIT;
      end
      S_WAIT: begin
        if ((resp_cnt == ALL_RESP) & ~drain_i)
          nxt_state = S_IDLE;
      end
      S_MCMD_RD: begin
        if (scmdaccept_i)
          nxt_state = S_SDATA;
      end
      S_SDATA: begin
        if (resp_seen)
          nxt_state = S_HDATA;
      end
      S_HDATA: begin
        nxt_state = rd_start ? S_MCMD_RD : S_IDLE;  // read in hdata cycle
      end
      default: nxt_state = S_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge n_hreset) begin
    if (!n_hreset) begin
      state    <= S_IDLE;
      cmd_cnt  <= '0;
      resp_cnt <= '0;
      rd_err_o <= 1'b0;
    end else begin
      state <= nxt_state;
      if (state == S_IDLE)
        cmd_cnt <= '0;
      else if ((state == S_MCMD_WR) & scmdaccept_i)
        cmd_cnt <= cmd_cnt + 1'b1;
      if (state == S_IDLE)
        resp_cnt <= '0;
      else if (resp_i.sresplast & wr_busy_o)
        resp_cnt <= resp_cnt + 1'b1;   // early responses count too
      if ((state == S_SDATA) & resp_seen)
        rd_err_o <= (resp_i.sresp == RESP_FAIL) | (resp_i.sresp == RESP_ERR);
    end
  end

  // read line capture
  always_ff @(posedge hclk) begin
    if ((state == S_SDATA) & resp_seen)
      rd_line_o.flat <= resp_i.sdata;
  end

  // ---------------------------------------------------------------------
  // command outputs
  // ---------------------------------------------------------------------
  always_comb begin
    cmd_o.mcmd  = CMD_IDLE;
    cmd_o.maddr = '0;
    case (state)
      S_MCMD_WR: begin
        cmd_o.mcmd  = CMD_WR;
        cmd_o.maddr = wr_addr;
      end
      S_MCMD_RD: begin
        cmd_o.mcmd  = CMD_RD;
        cmd_o.maddr = `BASE_ADDR + rd_addr_i;
      end
      default: ;
    endcase
  end

  assign wr_busy_o = (state == S_MCMD_WR) | (state == S_WAIT);
  assign rd_busy_o = (state == S_MCMD_RD) | (state == S_SDATA);
  assign hdata_o   = (state == S_HDATA);

endmodule

`default_nettype wire

// File: hdl/ahb_resp_gen.sv
// AHB output side of the write-buffer bridge
// write stall while a full fifo drains, read wait states, and the
// read word with its OKAY or ERROR response
`timescale 1ns/1ns
`default_nettype none

module ahb_resp_gen import ahb_pkg::*, ocp_pkg::*; (
  input  wire logic       hclk,
  input  wire logic       n_hreset,
  input  wire logic       last_line_wr_i,
  input  wire logic       drain_i,
  input  wire logic       wr_busy_i,
  input  wire logic       rd_busy_i,
  input  wire logic       hdata_i,
  input  wire ocp_line_u  rd_line_i,
  input  wire logic       rd_err_i,
  input  wire logic [1:0] rd_slot_i,
  output logic            hready_o,
  output hresp_e          hresp_o,
  output logic [31:0]     hrdata_o
);

  logic stall_q;   // fifo full, held until the drain has finished

  always_ff @(posedge hclk or negedge n_hreset) begin
    if (!n_hreset) begin
      stall_q <= 1'b0;
    end else if (last_line_wr_i) begin
      stall_q <= 1'b1;
    end else if (~wr_busy_i & ~drain_i) begin
      stall_q <= 1'b0;
    end
  end

  // low from the last line write until the fsm is back in idle
  assign hready_o = ~(last_line_wr_i | (stall_q & (wr_busy_i | drain_i)) | rd_busy_i);

  // read data phase ends in the hdata cycle
  assign hresp_o  = (hdata_i & rd_err_i) ? HR_ERROR : HR_OKAY;
  assign hrdata_o = hdata_i ? rd_line_i.word[rd_slot_i] : 32'h0;

endmodule

`default_nettype wire

// File: hdl/ahb2ocp_bridge.sv
// AHB to OCP write-buffer bridge, top level
// AHB word writes packed into lines, drained as two-beat OCP
// write bursts; single AHB reads map to one OCP read
`include "bridge_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module ahb2ocp_bridge import ahb_pkg::*, ocp_pkg::*; (
  input  wire logic        hclk,
  input  wire logic        n_hreset,
  input  wire ahb_addr_s   ahb_i,
  input  wire logic [31:0] hwdata_i,
  input  wire logic        scmdaccept_i,
  input  wire logic        sdataaccept_i,
  input  wire ocp_resp_s   resp_i,
  output logic             hready_o,
  output hresp_e           hresp_o,
  output logic [31:0]      hrdata_o,
  output ocp_cmd_s         cmd_o,
  output ocp_data_s        data_o
);

  // ---------------------------------------------------------------------
  // internal wires
  // ---------------------------------------------------------------------
  ocp_line_u              line;
  logic                   line_wr;
  logic [`OFFSET_W-1:0]   offset;
  logic                   rd_req;
  logic [1:0]             rd_slot;
  logic [`OCP_ADDR_W-1:0] rd_addr;
  logic                   drain;
  logic                   empty;
  logic                   last_line_wr;
  logic                   wr_busy;
  logic                   rd_busy;
  ocp_line_u              rd_line;
  logic                   rd_err;
  logic                   hdata;

  ahb_wr_pack ahb_wr_pack_i (
    .hclk       (hclk),
    .n_hreset   (n_hreset),
    .ahb_i      (ahb_i),
    .hwdata_i   (hwdata_i),
    .hready_i   (hready_o),
    .line_o     (line),
    .line_wr_o  (line_wr),
    .offset_o   (offset),
    .rd_req_o   (rd_req),
    .rd_slot_o  (rd_slot),
    .rd_addr_o  (rd_addr)
  );

  line_fifo line_fifo_i (
    .hclk           (hclk),
    .n_hreset       (n_hreset),
    .line_i         (line),
    .line_wr_i      (line_wr),
    .sdataaccept_i  (sdataaccept_i),
    .data_o         (data_o),
    .drain_o        (drain),
    .empty_o        (empty),
    .last_line_wr_o (last_line_wr)
  );

  ocp_cmd_fsm ocp_cmd_fsm_i (
    .hclk         (hclk),
    .n_hreset     (n_hreset),
    .drain_i      (drain),
    .empty_i      (empty),
    .offset_i     (offset),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .scmdaccept_i (scmdaccept_i),
    .resp_i       (resp_i),
    .cmd_o        (cmd_o),
    .wr_busy_o    (wr_busy),
    .rd_busy_o    (rd_busy),
    .rd_line_o    (rd_line),
    .rd_err_o     (rd_err),
    .hdata_o      (hdata)
  );

  ahb_resp_gen ahb_resp_gen_i (
    .hclk           (hclk),
    .n_hreset       (n_hreset),
    .last_line_wr_i (last_line_wr),
    .drain_i        (drain),
    .wr_busy_i      (wr_busy),
    .rd_busy_i      (rd_busy),
    .hdata_i        (hdata),
    .rd_line_i      (rd_line),
    .rd_err_i       (rd_err),
    .rd_slot_i      (rd_slot),
    .hready_o       (hready_o),
    .hresp_o        (hresp_o),
    .hrdata_o       (hrdata_o)
  );

endmodule

`default_nettype wire

// File: test/ocp_bridge_properties.sv
// protocol checks for the AHB to OCP bridge, bound to the top level
// OCP request and write data hold under back-pressure, AHB ERROR timing
`timescale 1ns/1ns
`default_nettype none

module ocp_bridge_properties import ahb_pkg::*, ocp_pkg::*; (
  input wire logic      hclk,
  input wire logic      n_hreset,
  input wire ocp_cmd_s  cmd_i,
  input wire ocp_data_s data_i,
  input wire logic      scmdaccept_i,
  input wire logic      sdataaccept_i,
  input wire logic      hready_i,
  input wire hresp_e    hresp_i
);

  int fail_cnt = 0;   // failed assertion count

  // request group frozen until scmdaccept
  cmd_hold: assert property (@(posedge hclk) disable iff (!n_hreset)
    (cmd_i.mcmd != CMD_IDLE) && !scmdaccept_i |=> $stable(cmd_i))
    else begin
      $error("mcmd or maddr changed before scmdaccept");
      fail_cnt++;
    end

  // beat stays valid and unchanged until sdataaccept
  data_hold: assert property (@(posedge hclk) disable iff (!n_hreset)
    data_i.mdatavalid && !sdataaccept_i |=> data_i.mdatavalid && $stable(data_i))
    else begin
      $error("write beat changed before sdataaccept");
      fail_cnt++;
    end

  err_ready: assert property (@(posedge hclk) disable iff (!n_hreset)
    (hresp_i == HR_ERROR) |-> hready_i)
    else begin
      $error("hresp ERROR with hready low");
      fail_cnt++;
    end

endmodule

bind ahb2ocp_bridge ocp_bridge_properties ocp_bridge_properties_i (
  .hclk          (hclk),
  .n_hreset      (n_hreset),
  .cmd_i         (cmd_o),
  .data_i        (data_o),
  .scmdaccept_i  (scmdaccept_i),
  .sdataaccept_i (sdataaccept_i),
  .hready_i      (hready_o),
  .hresp_i       (hresp_o)
);

`default_nettype wire

// File: test/tb_ahb2ocp_bridge.sv
// testbench for the AHB to OCP write-buffer bridge
// AHB master driver, OCP slave model with random accept gaps,
// reference beats and addresses, read word and error checks
`include "bridge_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_ahb2ocp_bridge import ahb_pkg::*, ocp_pkg::*; ();

  localparam logic [31:0] SEED           = 32'h614f;
  localparam int          WAIT_LIMIT     = 4000;   // cycles per wait loop
  localparam int          NUM_FILLS      = 4;
  localparam int          WORDS_PER_FILL = `FIFO_DEPTH * 4;
  localparam int          CMDS_PER_FILL  = `FIFO_DEPTH / `BURST_LEN;

  logic                   hclk = 1'b0;
  logic                   n_hreset;
  ahb_addr_s              ahb_i;
  logic [31:0]            hwdata_i;
  logic                   scmdaccept_i;
  logic                   sdataaccept_i;
  ocp_resp_s              resp_i;
  logic                   hready_o;
  hresp_e                 hresp_o;
  logic [31:0]            hrdata_o;
  ocp_cmd_s               cmd_o;
  ocp_data_s              data_o;

  // stimulus record
  logic [31:0]            ahb_words [NUM_FILLS * WORDS_PER_FILL];
  logic [`OFFSET_W-1:0]   fill_off [NUM_FILLS];
  int                     start_resp [NUM_FILLS];   // responses seen at fill start
  logic [31:0]            data_state = SEED;        // write data stream
  logic [31:0]            gap_state  = SEED;        // slave accept gaps

  // slave model state
  logic                   gap_mode;                 // 0 accepts at once
  sresp_e                 rd_kind;
  logic [`LINE_W-1:0]     rd_line;
  logic [`OCP_ADDR_W-1:0] rd_addr_seen;
  int                     rd_cmds = 0;
  int                     wr_cmds = 0;
  int                     bursts_done = 0;
  int                     resp_sent = 0;
  logic [`LINE_W-1:0]     beat_q [$];
  logic                   last_q [$];
  logic [`OCP_ADDR_W-1:0] addr_q [$];
  int                     beats_checked = 0;
  int                     cmds_checked = 0;

  ahb2ocp_bridge ahb2ocp_bridge_i (
    .hclk          (hclk),
    .n_hreset      (n_hreset),
    .ahb_i         (ahb_i),
    .hwdata_i      (hwdata_i),
    .scmdaccept_i  (scmdaccept_i),
    .sdataaccept_i (sdataaccept_i),
    .resp_i        (resp_i),
    .hready_o      (hready_o),
    .hresp_o       (hresp_o),
    .hrdata_o      (hrdata_o),
    .cmd_o         (cmd_o),
    .data_o        (data_o)
  );

  always #10 hclk = ~hclk;   // 20 ns period

  // ---------------------------------------------------------------------
  // reference model and checks
  // ---------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // beat k of a fill in haddr[3:2] word order
  function automatic logic [`LINE_W-1:0] exp_beat(input int fill_base, input int k);
    int w;
    w = fill_base + 4 * k;
    return {ahb_words[w + 3], ahb_words[w + 2], ahb_words[w + 1], ahb_words[w]};
  endfunction

  function automatic logic [`OCP_ADDR_W-1:0] exp_addr(input logic [`OFFSET_W-1:0] offset,
                                                      input int k);
    return `BASE_ADDR + `OCP_ADDR_W'(offset) + `OCP_ADDR_W'(k * `BURST_BYTES);
  endfunction

  task automatic check_value(input string name, input logic [`LINE_W-1:0] expected,
                             input logic [`LINE_W-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display(">>> FAIL");
    $fatal(1, "wait loop ran out");
  endtask

  // a failed protocol assertion ends the run
  always @(negedge hclk) begin : watch_assertions
    if (ahb2ocp_bridge_i.ocp_bridge_properties_i.fail_cnt != 0) begin
      $display("protocol assertion failed");
      $display(">>> FAIL");
      $fatal(1, "assertion failure");
    end
  end

  // ---------------------------------------------------------------------
  // AHB master
  // ---------------------------------------------------------------------
  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(negedge hclk);
    ahb_i = '{sel: 1'b1, trans: HT_NONSEQ, addr: addr, write: 1'b1, ready_in: 1'b1};
    n = 0;
    while (!hready_o && n < WAIT_LIMIT) begin   // stalled while a fill drains
      @(negedge hclk);
      n++;
    end
    if (!hready_o)
      stop_on_timeout("write address phase never saw hready high");
    @(negedge hclk);
    ahb_i.sel   = 1'b0;
    ahb_i.trans = HT_IDLE;
    hwdata_i    = data;   // data phase
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output hresp_e rresp);
    int n;
    @(negedge hclk);
    ahb_i = '{sel: 1'b1, trans: HT_NONSEQ, addr: addr, write: 1'b0, ready_in: 1'b1};
    n = 0;
    while (!hready_o && n < WAIT_LIMIT) begin
      @(negedge hclk);
      n++;
    end
    if (!hready_o)
      stop_on_timeout("read address phase never saw hready high");
    @(negedge hclk);
    ahb_i.sel   = 1'b0;
    ahb_i.trans = HT_IDLE;
    n = 0;
    while (!hready_o && n < WAIT_LIMIT) begin   // wait states until hdata
      @(negedge hclk);
      n++;
    end
    if (!hready_o)
      stop_on_timeout("read data phase never completed");
    rdata = hrdata_o;
    rresp = hresp_o;
  endtask

  task automatic write_fill(input int fill, input logic [31:0] addr);
    logic [31:0] word;
    int          i;
    fill_off[fill] = addr[`OFFSET_W-1:0];
    for (i = 0; i < WORDS_PER_FILL; i++) begin
      data_state = lcg_next(data_state);
      word       = data_state;
      ahb_words[fill * WORDS_PER_FILL + i] = word;
      ahb_write(addr + 32'(4 * i), word);
      if (i == 0)
        start_resp[fill] = resp_sent;
    end
  endtask

  // bursts of the given fills checked and answered and the bridge idle
  function automatic bit drain_complete(input int fills);
    return beats_checked == fills * `FIFO_DEPTH && cmds_checked == fills * CMDS_PER_FILL &&
           resp_sent == fills * CMDS_PER_FILL && hready_o && cmd_o.mcmd == CMD_IDLE;
  endfunction

  task automatic wait_drain(input int fills);
    int n;
    n = 0;
    while (!drain_complete(fills) && n < WAIT_LIMIT) begin
      @(negedge hclk);
      n++;
    end
    if (!drain_complete(fills))
      stop_on_timeout("line fifo drain did not finish");
  endtask

  // ---------------------------------------------------------------------
  // OCP slave model
  // ---------------------------------------------------------------------
  initial begin : ocp_slave
    logic [31:0] r;
    logic        take_cmd;
    logic        take_data;
    logic        take_resp;
    logic        rd_pending;
    int          rd_wait;
    scmdaccept_i  = 1'b0;
    sdataaccept_i = 1'b0;
    resp_i        = '0;
    rd_pending    = 1'b0;
    rd_wait       = 0;
    forever begin
      @(negedge hclk);
      gap_state = lcg_next(gap_state);
      r         = gap_state;
      take_cmd  = !gap_mode || (r[31:30] != 2'b00);   // 3 in 4 when gapped
      take_data = !gap_mode || (r[29:28] != 2'b00);
      take_resp = !gap_mode || (r[27:26] != 2'b00);

      // responses first, so none lands in its trigger's own cycle
      resp_i = '0;
      if (rd_pending) begin
        if (rd_wait == 0) begin
          resp_i.sresp     = rd_kind;
          resp_i.sresplast = 1'b1;
          resp_i.sdata     = rd_line;
          rd_pending       = 1'b0;
        end else begin
          rd_wait--;
        end
      end else if (resp_sent < wr_cmds && resp_sent < bursts_done && take_resp) begin
        resp_i.sresp     = RESP_DVA;   // one per burst after its cmd and last beat
        resp_i.sresplast = 1'b1;
        resp_sent++;
      end

      scmdaccept_i = 1'b0;
      if (n_hreset && cmd_o.mcmd != CMD_IDLE && take_cmd) begin
        scmdaccept_i = 1'b1;
        if (cmd_o.mcmd == CMD_WR) begin
          addr_q.push_back(cmd_o.maddr);
          wr_cmds++;
        end else begin
          rd_addr_seen = cmd_o.maddr;
          rd_cmds++;
          rd_pending = 1'b1;
          rd_wait    = gap_mode ? int'(r[2:0]) : 0;
        end
      end

      sdataaccept_i = 1'b0;
      if (n_hreset && data_o.mdatavalid && take_data) begin
        sdataaccept_i = 1'b1;
        beat_q.push_back(data_o.mdata);
        last_q.push_back(data_o.mdatalast);
        if (data_o.mdatalast)
          bursts_done++;
      end
    end
  end

  // compares recorded beats and addresses against the reference
  always @(negedge hclk) begin : compare_ocp
    int fill;
    int k;
    if (beat_q.size() != 0) begin
      fill = beats_checked / `FIFO_DEPTH;
      k    = beats_checked % `FIFO_DEPTH;
      check_value("write beat", exp_beat(fill * WORDS_PER_FILL, k), beat_q.pop_front());
      check_value("mdatalast", ((k + 1) % `BURST_LEN) == 0, last_q.pop_front());
      beats_checked++;
    end
    if (addr_q.size() != 0) begin
      fill = cmds_checked / CMDS_PER_FILL;
      k    = cmds_checked % CMDS_PER_FILL;
      check_value("write maddr", exp_addr(fill_off[fill], k), addr_q.pop_front());
      cmds_checked++;
    end
  end

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------
  initial begin : main
    logic [31:0]            rdata;
    hresp_e                 rresp;
    logic [31:0]            raddr;
    logic [`OCP_ADDR_W-1:0] exp_rd_addr;
    int                     slot;
    int                     w;
    n_hreset = 1'b0;
    ahb_i    = '0;
    hwdata_i = '0;
    gap_mode = 1'b0;
    rd_kind  = RESP_DVA;
    rd_line  = '0;
    repeat (2) @(negedge hclk);
    n_hreset = 1'b1;
    @(negedge hclk);

    // reset values
    check_value("reset hready", 1'b1, hready_o);
    check_value("reset hresp", HR_OKAY, hresp_o);
    check_value("reset mcmd", CMD_IDLE, cmd_o.mcmd);
    check_value("reset mdatavalid", 1'b0, data_o.mdatavalid);

    // one fill with the slave accepting at once
    write_fill(0, 32'h0000_1000);
    wait_drain(1);

    // random gaps with the next fills issued straight away and stalled
    gap_mode = 1'b1;
    write_fill(1, 32'h0001_2340);
    write_fill(2, 32'h0010_0060);
    check_value("fill 2 start after drain", 2 * CMDS_PER_FILL, start_resp[2]);
    write_fill(3, 32'h00bf_ff80);   // only low 21 bits form the offset
    check_value("fill 3 start after drain", 3 * CMDS_PER_FILL, start_resp[3]);
    wait_drain(4);

    // single reads of each word slot
    for (slot = 0; slot < 4; slot++) begin
      for (w = 0; w < 4; w++) begin
        data_state = lcg_next(data_state);
        rd_line[w * 32 +: 32] = data_state;
      end
      rd_kind     = RESP_DVA;
      raddr       = 32'h0003_4560 + 32'(slot * 'h104);
      exp_rd_addr = `BASE_ADDR + (raddr[`OCP_ADDR_W-1:0] & ~`OCP_ADDR_W'(4'hf));
      ahb_read(raddr, rdata, rresp);
      check_value("read word", rd_line[slot * 32 +: 32], rdata);
      check_value("read hresp", HR_OKAY, rresp);
      check_value("read maddr", exp_rd_addr, rd_addr_seen);
      check_value("read commands", slot + 1, rd_cmds);
    end

    // error responses map to AHB ERROR
    rd_kind = RESP_ERR;
    ahb_read(32'h0000_0208, rdata, rresp);
    check_value("read ERR hresp", HR_ERROR, rresp);
    rd_kind = RESP_FAIL;
    ahb_read(32'h0000_0304, rdata, rresp);
    check_value("read FAIL hresp", HR_ERROR, rresp);

    repeat (4) @(negedge hclk);
    if (ahb2ocp_bridge_i.ocp_bridge_properties_i.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("protocol assertions failed during the run");
      $display(">>> FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/ocp_pkg.sv
hdl/ahb_wr_pack.sv
hdl/line_fifo.sv
hdl/ocp_cmd_fsm.sv
hdl/ahb_resp_gen.sv
hdl/ahb2ocp_bridge.sv
test/ocp_bridge_properties.sv
test/tb_ahb2ocp_bridge.sv
